// File: tests/dot_golden.txt
# op adr value, hex: W write, R read and compare, P poll adr until value bits set
# T ends a test, its value is the test number
R 9 00000000
R 0 00000000
R A 00000000
T 0 1
W 0 FFFF0003
W 1 00000004
W 2 00000005
W 3 00000006
W 4 00000007
W 5 00000008
W 6 00000009
W 7 0000000A
R 0 00000003
R 7 0000000A
T 0 2
W 8 00000001
P 9 00000001
R A 000000BC
R 9 00000000
T 0 3
W 0 0000FFFF
W 1 0000FFFF
W 8 00000001
W 2 00008000
W 8 00000001
W 6 00001234
W 8 00000001
W 4 0000F000
W 8 00000001
P 9 00000002
R 9 00000043
R A 000000B1
R A 00000093
R A 0000B641
R A 00003609
T 0 4
W 8 00000001
W 8 00000001
W 8 00000001
W 8 00000001
P 9 00000002
W 8 00000001
R 9 00000047
W 9 00000004
R A 00003609
W 8 00000001
P 9 00000002
R 9 00000043
R A 00003609
R A 00003609
R A 00003609
R A 00003609
T 0 5
R A 00000000
R 9 00000000
T 0 6

// File: vlog.f
src/dot_pkg.sv
src/mac_pipeline.sv
src/result_fifo.sv
src/dot_regs.sv
src/dot_engine_top.sv
tests/dot_engine_checker.sv
tests/dot_engine_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module dot_engine_tb \
		-Mdir obj_dir -f vlog.f

run: compile
	./obj_dir/Vdot_engine_tb | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/dot_engine_tb.sv
//==============================
// Testbench replaying golden bus
// operations against the engine
//==============================

`timescale 1ns/10ps

module dot_engine_tb;

   logic                      clk;
   logic                      rst;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   logic [dot_pkg::ADR_W-1:0] wb_adr;
   logic [dot_pkg::BUS_W-1:0] wb_dat_w;
   logic [dot_pkg::BUS_W-1:0] wb_dat_r;
   logic                      wb_ack;

   // Golden operations, one entry per file line
   byte                       op_q  [$];
   logic [dot_pkg::ADR_W-1:0] adr_q [$];
   logic [dot_pkg::BUS_W-1:0] val_q [$];
   int                        test_errs;
   int                        total_errs;
   int                        tests_ok;
   int                        tests_bad;
   int                        cycles;
   int                        limit;

   dot_engine_top u_dot_engine_top (
      .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
   );

   always #2 clk = ~clk;

   //==============================
   // Run limit
   //==============================
   always @(posedge clk) begin
      cycles++;
      if (limit != 0 && cycles > limit) begin
         $display("Timeout after %0d cycles, a bus cycle or poll never finished", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   // Comment lines start with #, others hold op, address and value
   task automatic load_golden();
      int               fd;
      int               code;
      byte              c;
      logic [31:0]      a;
      logic [31:0]      v;
      logic [8*128-1:0] rest;
      fd = $fopen("tests/dot_golden.txt", "r");
      if (fd == 0) begin
         return;
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", c);
         if (code != 1) break;
         if (c == "#") begin
            code = $fgets(rest, fd);
         end else begin
            code = $fscanf(fd, "%h %h", a, v);
            op_q.push_back(c);
            adr_q.push_back(a[dot_pkg::ADR_W-1:0]);
            val_q.push_back(v);
         end
      end
      $fclose(fd);
   endtask

   // Classic cycle, request held through the ack cycle
   task automatic bus_cycle(input logic we, input logic [dot_pkg::ADR_W-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      do begin
         @(posedge clk);
         #1;
      end while (!wb_ack);
      rdat = wb_dat_r;
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic check_read(input logic [dot_pkg::ADR_W-1:0] adr, input logic [31:0] exp);
      logic [31:0] got;
      bus_cycle(1'b0, adr, '0, got);
      assert (got === exp) else begin
         $display("** Error at %0t ns: wb_dat_r (adr %0h) = %h, expected %h",
                  $time, adr, got, exp);
         test_errs++;
      end
   endtask

   // Reads until every bit of the mask is set
   task automatic poll_bits(input logic [dot_pkg::ADR_W-1:0] adr, input logic [31:0] mask);
      logic [31:0] got;
      got = '0;
      while ((got & mask) != mask) begin
         bus_cycle(1'b0, adr, '0, got);
      end
   endtask

   //==============================
   // Main sequence
   //==============================
   initial begin
      logic [31:0] unused_rd;
      clk      = 1'b0;
      rst      = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      load_golden();
      if (op_q.size() == 0) begin
         $display("Golden file missing or empty, nothing was run");
         total_errs++;
      end
      limit = 40 * op_q.size() + 10;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;
      for (int i = 0; i < op_q.size(); i++) begin
         case (op_q[i])
            "W": bus_cycle(1'b1, adr_q[i], val_q[i], unused_rd);
            "R": check_read(adr_q[i], val_q[i]);
            "P": poll_bits(adr_q[i], val_q[i]);
            "T": begin
               if (test_errs == 0) begin
                  $display("Test %0d: passed", val_q[i]);
                  tests_ok++;
               end else begin
                  $display("Test %0d: failed with %0d errors", val_q[i], test_errs);
                  tests_bad++;
               end
               total_errs += test_errs;
               test_errs = 0;
            end
            default: begin
               $display("Unknown operation on golden entry %0d", i);
               total_errs++;
            end
         endcase
      end
      total_errs += test_errs;
      $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, total_errs);
      if (total_errs == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: tests/dot_engine_checker.sv
//==============================
// Bound assertions for bus ack,
// start credits and pipeline latency
//==============================

`timescale 1ns/10ps

module dot_engine_checker (
   input logic                      clk,
   input logic                      rst,
   input logic                      wb_cyc,
   input logic                      wb_stb,
   input logic                      wb_ack,
   input logic                      launch,
   input logic                      result_valid,
   input logic [dot_pkg::CNT_W-1:0] in_flight,
   input logic [dot_pkg::CNT_W-1:0] count
);

   // Slots already claimed by running jobs and queued results
   logic [dot_pkg::CNT_W:0] pending;

   assign pending = {1'b0, in_flight} + {1'b0, count};

   // Ack only answers a request the master still holds
   ack_with_request: assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack without a held request");

   // Running jobs plus queued results never outgrow the queue
   credit_bound: assert property (@(posedge clk) disable iff (rst)
      pending <= dot_pkg::FIFO_DEPTH)
      else $error("more jobs pending than queue slots");

   // Every launch and only a launch yields result_valid LATENCY cycles later
   valid_after_latency: assert property (@(posedge clk) disable iff (rst)
      result_valid == $past(launch, dot_pkg::LATENCY))
      else $error("result_valid not LATENCY cycles after launch");

endmodule

bind dot_regs dot_engine_checker u_checker (
   .clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .launch, .result_valid, .in_flight, .count
);

// File: src/dot_engine_top.sv
//==============================
// Dot-product engine top level
//==============================

`timescale 1ns/10ps

module dot_engine_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [dot_pkg::ADR_W-1:0] wb_adr,
   input  logic [dot_pkg::BUS_W-1:0] wb_dat_w,
   output logic [dot_pkg::BUS_W-1:0] wb_dat_r,
   output logic                      wb_ack
);

   // Operands from the register file
   logic [dot_pkg::DATA_W-1:0] op0, op1, op2, op3;
   logic [dot_pkg::DATA_W-1:0] op4, op5, op6, op7;
   logic                       launch;
   // Pipeline output into the queue
   logic [dot_pkg::DATA_W-1:0] result;
   logic                       result_valid;
   // Queue state back to the register block
   logic                       pop;
   logic [dot_pkg::DATA_W-1:0] head;
   logic [dot_pkg::CNT_W-1:0]  count;
   logic                       empty;
   logic                       full;

   dot_regs u_regs (
      .clk, .rst,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
      .op0, .op1, .op2, .op3, .op4, .op5, .op6, .op7,
      .launch, .result_valid,
      .pop, .head, .count, .empty, .full
   );

   // Launch doubles as the pipeline's valid_in
   mac_pipeline u_pipe (
      .clk, .rst,
      .op0, .op1, .op2, .op3, .op4, .op5, .op6, .op7,
      .valid_in  (launch),
      .result    (result),
      .valid_out (result_valid)
   );

   result_fifo u_fifo (
      .clk, .rst,
      .push      (result_valid),
      .push_data (result),
      .pop, .head, .count, .empty, .full
   );

endmodule

// File: src/dot_regs.sv
//==============================
// Wishbone register block with start
// credit check and result pop
//==============================

`timescale 1ns/10ps

module dot_regs (
   input  logic                       clk,
   input  logic                       rst,
   // Wishbone classic slave
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [dot_pkg::ADR_W-1:0]  wb_adr,
   input  logic [dot_pkg::BUS_W-1:0]  wb_dat_w,
   output logic [dot_pkg::BUS_W-1:0]  wb_dat_r,
   output logic                       wb_ack,
   // Operands and start to the pipeline
   output logic [dot_pkg::DATA_W-1:0] op0,
   output logic [dot_pkg::DATA_W-1:0] op1,
   output logic [dot_pkg::DATA_W-1:0] op2,
   output logic [dot_pkg::DATA_W-1:0] op3,
   output logic [dot_pkg::DATA_W-1:0] op4,
   output logic [dot_pkg::DATA_W-1:0] op5,
   output logic [dot_pkg::DATA_W-1:0] op6,
   output logic [dot_pkg::DATA_W-1:0] op7,
   output logic                       launch,
   input  logic                       result_valid,
   // Queue side
   output logic                       pop,
   input  logic [dot_pkg::DATA_W-1:0] head,
   input  logic [dot_pkg::CNT_W-1:0]  count,
   input  logic                       empty,
   input  logic                       full
);

   logic                          ack_r;
   logic [dot_pkg::DATA_W-1:0]    ops_r [dot_pkg::N_OPS];
   logic [dot_pkg::CNT_W-1:0]     in_flight;
   logic                          overflow_r;
   logic                          wr_cyc;
   logic                          rd_cyc;
   logic                          op_hit;
   logic [dot_pkg::ADR_W-1:0]     op_off;
   logic [dot_pkg::OP_IDX_W-1:0]  op_idx;
   // One extra bit, in-flight plus queued can reach twice the depth
   logic [dot_pkg::CNT_W:0]       pending;
   logic                          credit_ok;
   logic                          start_req;

   //==============================
   // Bus decode
   //==============================

   // Ack one cycle after the request, single pulse
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack_r <= 1'b0;
      end else begin
         ack_r <= wb_cyc & wb_stb & ~ack_r;
      end
   end

   // Accesses act in the ack cycle
   assign wr_cyc = ack_r & wb_we;
   assign rd_cyc = ack_r & ~wb_we;
   assign op_hit = (wb_adr >= dot_pkg::ADR_OP0) && (wb_adr <= dot_pkg::ADR_OP_LAST);
   assign op_off = wb_adr - dot_pkg::ADR_OP0;
   assign op_idx = op_off[dot_pkg::OP_IDX_W-1:0];

   // Start is refused once every queue slot is spoken for
   assign pending   = {1'b0, in_flight} + {1'b0, count};
   assign credit_ok = (pending < {1'b0, dot_pkg::DEPTH_CNT});
   assign start_req = wr_cyc & (wb_adr == dot_pkg::ADR_CTRL);
   assign launch    = start_req & credit_ok;
   // Empty queue is never popped
   assign pop       = rd_cyc & (wb_adr == dot_pkg::ADR_RESULT) & ~empty;

   //==============================
   // Registers
   //==============================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < dot_pkg::N_OPS; i++) begin
            ops_r[i] <= '0;
         end
         in_flight  <= '0;
         overflow_r <= 1'b0;
      end else begin
         if (wr_cyc && op_hit) begin
            ops_r[op_idx] <= wb_dat_w[dot_pkg::DATA_W-1:0];
         end
         // Jobs between launch and queue push
         case ({launch, result_valid})
            2'b10:   in_flight <= in_flight + 1'b1;
            2'b01:   in_flight <= in_flight - 1'b1;
            default: in_flight <= in_flight;
         endcase
         // Sticky until software clears it through STATUS
         if (start_req && !credit_ok) begin
            overflow_r <= 1'b1;
         end else if (wr_cyc && (wb_adr == dot_pkg::ADR_STATUS) &&
                      wb_dat_w[dot_pkg::STAT_OVF]) begin
            overflow_r <= 1'b0;
         end
      end
   end

   // Read mux, upper bus bits stay zero
   always_comb begin
      wb_dat_r = '0;
      if (op_hit) begin
         wb_dat_r[dot_pkg::DATA_W-1:0] = ops_r[op_idx];
      end else if (wb_adr == dot_pkg::ADR_STATUS) begin
         wb_dat_r[dot_pkg::STAT_AVAIL] = ~empty;
         wb_dat_r[dot_pkg::STAT_FULL]  = full;
         wb_dat_r[dot_pkg::STAT_OVF]   = overflow_r;
         wb_dat_r[dot_pkg::STAT_CNT_LSB +: dot_pkg::CNT_W] = count;
      end else if (wb_adr == dot_pkg::ADR_RESULT && !empty) begin
         wb_dat_r[dot_pkg::DATA_W-1:0] = head;
      end
   end

   assign wb_ack = ack_r;

   // Loose operand ports
   assign op0 = ops_r[0];
   assign op1 = ops_r[1];
   assign op2 = ops_r[2];
   assign op3 = ops_r[3];
   assign op4 = ops_r[4];
   assign op5 = ops_r[5];
   assign op6 = ops_r[6];
   assign op7 = ops_r[7];

endmodule

// File: src/result_fifo.sv
//==============================
// Result queue, circular buffer
// with occupancy count
//==============================

`timescale 1ns/10ps

module result_fifo (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       push,
   input  logic [dot_pkg::DATA_W-1:0] push_data,
   input  logic                       pop,
   output logic [dot_pkg::DATA_W-1:0] head,
   output logic [dot_pkg::CNT_W-1:0]  count,
   output logic                       empty,
   output logic                       full
);

   logic [dot_pkg::DATA_W-1:0] mem [dot_pkg::FIFO_DEPTH];
   logic [dot_pkg::PTR_W-1:0]  wr_ptr;
   logic [dot_pkg::PTR_W-1:0]  rd_ptr;
   logic [dot_pkg::CNT_W-1:0]  count_r;
   logic                       do_push;
   logic                       do_pop;

   // Pop on empty is dropped
   assign do_pop  = pop & ~empty;
   // A full queue still takes a push when the head leaves
   assign do_push = push & (~full | do_pop);

   // Storage, written at the tail
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_r <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         // Push and pop together leave count alone
         case ({do_push, do_pop})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   assign head  = mem[rd_ptr];
   assign count = count_r;
   assign empty = (count_r == '0);
   assign full  = (count_r == dot_pkg::DEPTH_CNT);

endmodule

// File: src/mac_pipeline.sv
//==============================
// Four-stage multiply and adder-tree
// pipeline with valid delay line
//==============================

`timescale 1ns/10ps

module mac_pipeline (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [dot_pkg::DATA_W-1:0] op0,
   input  logic [dot_pkg::DATA_W-1:0] op1,
   input  logic [dot_pkg::DATA_W-1:0] op2,
   input  logic [dot_pkg::DATA_W-1:0] op3,
   input  logic [dot_pkg::DATA_W-1:0] op4,
   input  logic [dot_pkg::DATA_W-1:0] op5,
   input  logic [dot_pkg::DATA_W-1:0] op6,
   input  logic [dot_pkg::DATA_W-1:0] op7,
   input  logic                      valid_in,
   output logic [dot_pkg::DATA_W-1:0] result,
   output logic                      valid_out
);

   // Loose operand ports gathered for indexed access
   logic [dot_pkg::DATA_W-1:0]   ops_in [dot_pkg::N_OPS];
   logic [dot_pkg::DATA_W-1:0]   in_r   [dot_pkg::N_OPS];
   // Full-width products before truncation
   logic [2*dot_pkg::DATA_W-1:0] prod   [4];
   logic [dot_pkg::DATA_W-1:0]   mult_r [4];
   logic [dot_pkg::DATA_W-1:0]   add_r  [2];
   logic [dot_pkg::DATA_W-1:0]   sum_r;
   // One bit per stage so each in-flight job is tracked on its own
   logic [dot_pkg::LATENCY-1:0]  valid_sr;

   assign ops_in[0] = op0;
   assign ops_in[1] = op1;
   assign ops_in[2] = op2;
   assign ops_in[3] = op3;
   assign ops_in[4] = op4;
   assign ops_in[5] = op5;
   assign ops_in[6] = op6;
   assign ops_in[7] = op7;

   // Pair products before the wrap to DATA_W bits
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         prod[i] = in_r[2*i] * in_r[2*i+1];
      end
   end

   // Datapath stages
   always_ff @(posedge clk) begin
      // Stage 1 captures the operands
      for (int i = 0; i < dot_pkg::N_OPS; i++) begin
         in_r[i] <= ops_in[i];
      end
      // Stage 2 multiplies and wraps mod 2^16
      for (int i = 0; i < 4; i++) begin
         mult_r[i] <= prod[i][dot_pkg::DATA_W-1:0];
      end
      // Stage 3 is the first adder level
      add_r[0] <= mult_r[0] + mult_r[1];
      add_r[1] <= mult_r[2] + mult_r[3];
      // Stage 4 holds the final sum
      sum_r <= add_r[0] + add_r[1];
   end

   // Valid shift register with one bit per datapath stage
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= {valid_sr[dot_pkg::LATENCY-2:0], valid_in};
      end
   end

   assign result    = sum_r;
   assign valid_out = valid_sr[dot_pkg::LATENCY-1];

endmodule

// File: src/dot_pkg.sv
//==============================
// Dot-product engine widths, depths,
// pipeline latency and register map
//==============================

package dot_pkg;

   // Data and bus widths
   localparam int DATA_W = 16;
   localparam int BUS_W  = 32;
   localparam int ADR_W  = 4;

   // Operand count and its index width
   localparam int N_OPS    = 8;
   localparam int OP_IDX_W = 3;

   // Pipeline depth, valid_in to valid_out
   localparam int LATENCY = 4;

   // Result queue sizing
   localparam int FIFO_DEPTH = 4;
   localparam int CNT_W      = 3;
   localparam int PTR_W      = 2;
   localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

   //==============================
   // Register map (word addresses)
   //==============================
   localparam logic [ADR_W-1:0] ADR_OP0     = 4'd0;
   localparam logic [ADR_W-1:0] ADR_OP_LAST = 4'd7;
   localparam logic [ADR_W-1:0] ADR_CTRL    = 4'd8;
   localparam logic [ADR_W-1:0] ADR_STATUS  = 4'd9;
   localparam logic [ADR_W-1:0] ADR_RESULT  = 4'd10;

   // STATUS bit positions
   localparam int STAT_AVAIL   = 0;
   localparam int STAT_FULL    = 1;
   localparam int STAT_OVF     = 2;
   localparam int STAT_CNT_LSB = 4;

endpackage
